//--- mips_exc_pkg.sv
`default_nettype none

package mips_exc_pkg;

    // decoded operation.
    typedef enum logic [3:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_BEQ,
        OP_BNE,
        OP_TEQ,
        OP_TNE,
        OP_MTC0,
        OP_MFC0,
        OP_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        EXC_CHK_NONE,
        EXC_CHK_SYSCALL,
        EXC_CHK_BREAK,
        EXC_CHK_TRAP,
        EXC_CHK_OVERFLOW,
        EXC_CHK_RESERVED
    } exc_chk_e;

    // cause.exccode values.
    typedef enum logic [4:0] {
        EXC_SYS = 5'h8,
        EXC_BP  = 5'h9,
        EXC_RI  = 5'hA,
        EXC_OV  = 5'hC,
        EXC_TR  = 5'hD
    } exc_code_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } instr_in_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     op;
        exc_chk_e    exc_chk;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        use_imm;
        logic        wr_en;
        logic [4:0]  cop0_reg;
    } decoded_t;

    typedef struct packed {
        logic        exception_happen;
        exc_code_e   exc_code;
        logic [31:0] epc;
        logic        in_bd;
        logic [31:0] vector;
    } exc_info_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        wr_en;
        logic [4:0]  wr_reg;
        logic [31:0] wr_data;
        logic        branch_taken;
        exc_info_t   exc;
    } exec_result_t;

    // cop0 register numbers.
    localparam logic [4:0] COP0_STATUS = 5'd12;
    localparam logic [4:0] COP0_CAUSE  = 5'd13;
    localparam logic [4:0] COP0_EPC    = 5'd14;
    localparam logic [4:0] COP0_EBASE  = 5'd15;

    localparam int STATUS_BEV_IDX = 22;

    localparam logic [31:0] STATUS_RESET = 32'h0040_0000;
    localparam logic [31:0] EBASE_RESET  = 32'h8000_0000;

endpackage

`default_nettype wire

//--- instr_decoder.sv
`default_nettype none

module instr_decoder
    import mips_exc_pkg::*;
#(
    parameter int IN_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  instr_in_t in_instr,
    output logic      in_credit,
    input  logic      ex_ready,
    output decoded_t  dec,
    output logic      dec_valid
);

    localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int CNT_W = $clog2(IN_DEPTH + 1);

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDI    = 6'h08;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_COP0    = 6'h10;
    localparam logic [5:0] FN_SYSCALL  = 6'h0C;
    localparam logic [5:0] FN_BREAK    = 6'h0D;
    localparam logic [5:0] FN_ADD      = 6'h20;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUB      = 6'h22;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2A;
    localparam logic [5:0] FN_TEQ      = 6'h34;
    localparam logic [5:0] FN_TNE      = 6'h36;
    localparam logic [4:0] COP_MF      = 5'h00;
    localparam logic [4:0] COP_MT      = 5'h04;

    instr_in_t        fifo_mem [IN_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             fifo_empty;
    instr_in_t        head;
    logic             head_valid;
    logic             dec_load;
    logic             pop;
    logic             push;
    logic             pop_mem;
    decoded_t         d;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // an empty fifo lets the incoming word straight through.
    assign fifo_empty = (count == '0);
    assign head       = fifo_empty ? in_instr : fifo_mem[rd_ptr];
    assign head_valid = !fifo_empty || in_valid;
    assign dec_load   = !dec_valid || ex_ready;
    assign pop        = head_valid && dec_load;
    assign push       = in_valid && !(fifo_empty && dec_load);
    assign pop_mem    = pop && !fifo_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= in_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            in_credit <= pop;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_mem) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop_mem})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (dec_load) begin
                dec_valid <= pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_load) begin
            dec <= d;
        end
    end

    // classify the head word.
    always_comb begin
        d          = '0;
        d.pc       = head.pc;
        d.op       = OP_NONE;
        d.exc_chk  = EXC_CHK_RESERVED;
        d.rs       = head.instr[25:21];
        d.rt       = head.instr[20:16];
        d.rd       = head.instr[15:11];
        d.imm      = {{16{head.instr[15]}}, head.instr[15:0]};
        d.cop0_reg = head.instr[15:11];
        case (head.instr[31:26])
            OPC_SPECIAL: begin
                case (head.instr[5:0])
                    FN_ADD:     d.op = OP_ADD;
                    FN_ADDU:    d.op = OP_ADDU;
                    FN_SUB:     d.op = OP_SUB;
                    FN_SUBU:    d.op = OP_SUBU;
                    FN_AND:     d.op = OP_AND;
                    FN_OR:      d.op = OP_OR;
                    FN_XOR:     d.op = OP_XOR;
                    FN_SLT:     d.op = OP_SLT;
                    FN_TEQ:     d.op = OP_TEQ;
                    FN_TNE:     d.op = OP_TNE;
                    FN_SYSCALL: d.exc_chk = EXC_CHK_SYSCALL;
                    FN_BREAK:   d.exc_chk = EXC_CHK_BREAK;
                    default:    d.op = OP_NONE;
                endcase
            end
            OPC_BEQ: d.op = OP_BEQ;
            OPC_BNE: d.op = OP_BNE;
            OPC_ADDI, OPC_ADDIU: begin
                d.op      = (head.instr[31:26] == OPC_ADDI) ? OP_ADD : OP_ADDU;
                d.use_imm = 1'b1;
                d.rd      = head.instr[20:16];
            end
            OPC_COP0: begin
                if (head.instr[25:21] == COP_MF) begin
                    d.op = OP_MFC0;
                    d.rd = head.instr[20:16];
                end else if (head.instr[25:21] == COP_MT) begin
                    d.op = OP_MTC0;
                end
            end
            default: d.op = OP_NONE;
        endcase
        // recognised ops get their check and write enable.
        if (d.op != OP_NONE) begin
            case (d.op)
                OP_ADD, OP_SUB: d.exc_chk = EXC_CHK_OVERFLOW;
                OP_TEQ, OP_TNE: d.exc_chk = EXC_CHK_TRAP;
                default:        d.exc_chk = EXC_CHK_NONE;
            endcase
            case (d.op)
                OP_BEQ, OP_BNE, OP_TEQ, OP_TNE, OP_MTC0: d.wr_en = 1'b0;
                default:                                 d.wr_en = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- exception_controller.sv
`default_nettype none

module exception_controller
    import mips_exc_pkg::*;
(
    input  decoded_t    dec,
    input  logic        overflow,
    input  logic        trap_cond,
    input  logic        prev_taken,
    input  logic        status_bev,
    input  logic [31:0] ebase,
    output exc_info_t   exc
);

    localparam logic [31:0] BOOT_EXC_BASE  = 32'hBFC0_0200;
    localparam logic [31:0] GEN_EXC_OFFSET = 32'h0000_0180;

    logic        happen;
    exc_code_e   code;
    logic [31:0] vector;

    always_comb begin
        happen = 1'b1;
        code   = EXC_SYS;
        case (dec.exc_chk)
            EXC_CHK_SYSCALL: begin
                code = EXC_SYS;
            end
            EXC_CHK_BREAK: begin
                code = EXC_BP;
            end
            EXC_CHK_RESERVED: begin
                code = EXC_RI;
            end
            EXC_CHK_TRAP: begin
                code   = EXC_TR;
                happen = trap_cond;
            end
            EXC_CHK_OVERFLOW: begin
                code   = EXC_OV;
                happen = overflow;
            end
            default: begin
                happen = 1'b0;
            end
        endcase
    end

    // bootstrap vectors while bev is set.
    always_comb begin
        if (status_bev) begin
            vector = BOOT_EXC_BASE + GEN_EXC_OFFSET;
        end else begin
            vector = ebase + GEN_EXC_OFFSET;
        end
    end

    always_comb begin
        exc = '0;
        if (happen) begin
            exc.exception_happen = 1'b1;
            exc.exc_code         = code;
            exc.vector           = vector;
            // a taken branch just before puts us in its delay slot.
            exc.in_bd            = prev_taken;
            exc.epc              = prev_taken ? dec.pc - 32'd4 : dec.pc;
        end
    end

endmodule

`default_nettype wire

//--- cop0_regs.sv
`default_nettype none

module cop0_regs
    import mips_exc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        mtc0_en,
    input  logic [4:0]  reg_sel,
    input  logic [31:0] wdata,
    input  logic        exc_commit,
    input  exc_info_t   exc,
    output logic [31:0] rdata,
    output logic        status_bev,
    output logic [31:0] ebase
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] ebase_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            status    <= STATUS_RESET;
            cause     <= '0;
            epc       <= '0;
            ebase_reg <= EBASE_RESET;
        end else begin
            // only status and ebase are writable.
            if (mtc0_en) begin
                case (reg_sel)
                    COP0_STATUS: status <= wdata;
                    COP0_EBASE:  ebase_reg <= wdata;
                    default:     ;
                endcase
            end
            if (exc_commit) begin
                epc        <= exc.epc;
                cause[6:2] <= exc.exc_code;
                cause[31]  <= exc.in_bd;
            end
        end
    end

    always_comb begin
        case (reg_sel)
            COP0_STATUS: rdata = status;
            COP0_CAUSE:  rdata = cause;
            COP0_EPC:    rdata = epc;
            COP0_EBASE:  rdata = ebase_reg;
            default:     rdata = '0;
        endcase
    end

    assign status_bev = status[STATUS_BEV_IDX];
    assign ebase      = ebase_reg;

endmodule

`default_nettype wire

//--- alu_execute.sv
`default_nettype none

module alu_execute
    import mips_exc_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  decoded_t     dec,
    input  logic         dec_valid,
    output logic         ex_ready,
    input  logic         res_ready,
    input  logic         prev_taken,
    output exec_result_t ex_result,
    output logic         ex_valid
);

    logic [31:0] regs [32];
    decoded_t    slot;
    logic        slot_valid;
    logic        commit;
    logic [31:0] op_a;
    logic [31:0] rt_val;
    logic [31:0] op_b;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] alu_res;
    logic        overflow;
    logic        trap_cond;
    logic        taken;
    logic        wr_en_eff;
    exc_info_t   exc;
    logic [31:0] cop0_rdata;
    logic        status_bev;
    logic [31:0] ebase;

    assign commit   = slot_valid && res_ready;
    assign ex_ready = commit || !slot_valid;
    assign ex_valid = slot_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= 1'b0;
        end else if (ex_ready) begin
            slot_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready) begin
            slot <= dec;
        end
    end

    // r0 always reads zero.
    assign op_a   = (slot.rs == 5'd0) ? '0 : regs[slot.rs];
    assign rt_val = (slot.rt == 5'd0) ? '0 : regs[slot.rt];
    assign op_b   = slot.use_imm ? slot.imm : rt_val;
    assign sum    = op_a + op_b;
    assign diff   = op_a - op_b;

    always_comb begin
        case (slot.op)
            OP_ADD, OP_ADDU: alu_res = sum;
            OP_SUB, OP_SUBU: alu_res = diff;
            OP_AND:          alu_res = op_a & op_b;
            OP_OR:           alu_res = op_a | op_b;
            OP_XOR:          alu_res = op_a ^ op_b;
            OP_SLT:          alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            OP_MFC0:         alu_res = cop0_rdata;
            default:         alu_res = '0;
        endcase
        case (slot.op)
            OP_ADD:  overflow = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
            OP_SUB:  overflow = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
            default: overflow = 1'b0;
        endcase
    end

    assign taken = ((slot.op == OP_BEQ) && (op_a == rt_val)) ||
                   ((slot.op == OP_BNE) && (op_a != rt_val));
    assign trap_cond = ((slot.op == OP_TEQ) && (op_a == rt_val)) ||
                       ((slot.op == OP_TNE) && (op_a != rt_val));
    assign wr_en_eff = slot.wr_en && !exc.exception_happen;

    always_comb begin
        ex_result              = '0;
        ex_result.pc           = slot.pc;
        ex_result.wr_en        = wr_en_eff;
        ex_result.wr_reg       = slot.rd;
        ex_result.wr_data      = wr_en_eff ? alu_res : '0;
        ex_result.branch_taken = taken;
        ex_result.exc          = exc;
    end

    always_ff @(posedge clk) begin
        if (commit && wr_en_eff && (slot.rd != 5'd0)) begin
            regs[slot.rd] <= alu_res;
        end
    end

    exception_controller exception_controller_i (
        .dec        (slot),
        .overflow   (overflow),
        .trap_cond  (trap_cond),
        .prev_taken (prev_taken),
        .status_bev (status_bev),
        .ebase      (ebase),
        .exc        (exc)
    );

    cop0_regs cop0_regs_i (
        .clk        (clk),
        .rst        (rst),
        .mtc0_en    (commit && (slot.op == OP_MTC0)),
        .reg_sel    (slot.cop0_reg),
        .wdata      (rt_val),
        .exc_commit (commit && exc.exception_happen),
        .exc        (exc),
        .rdata      (cop0_rdata),
        .status_bev (status_bev),
        .ebase      (ebase)
    );

endmodule

`default_nettype wire

//--- result_stage.sv
`default_nettype none

module result_stage
    import mips_exc_pkg::*;
#(
    parameter int OUT_CREDITS = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  exec_result_t ex_result,
    input  logic         ex_valid,
    output logic         res_ready,
    input  logic         out_credit,
    output logic         out_valid,
    output exec_result_t out_result,
    output logic         prev_taken
);

    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    logic             out_full;
    logic [CRD_W-1:0] credits;
    logic             load;

    // one record leaves per cycle while credit lasts.
    assign out_valid = out_full && (credits != '0);
    assign res_ready = !out_full || out_valid;
    assign load      = ex_valid && res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_full   <= 1'b0;
            credits    <= CRD_W'(OUT_CREDITS);
            prev_taken <= 1'b0;
        end else begin
            if (load) begin
                out_full   <= 1'b1;
                prev_taken <= ex_result.branch_taken;
            end else if (out_valid) begin
                out_full <= 1'b0;
            end
            case ({out_valid, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_result <= ex_result;
        end
    end

endmodule

`default_nettype wire

//--- exc_core_top.sv
`default_nettype none

module exc_core_top
    import mips_exc_pkg::*;
#(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  instr_in_t    in_instr,
    output logic         in_credit,
    output logic         out_valid,
    output exec_result_t out_result,
    input  logic         out_credit
);

    decoded_t     dec;
    logic         dec_valid;
    logic         ex_ready;
    exec_result_t ex_result;
    logic         ex_valid;
    logic         res_ready;
    logic         prev_taken;

    instr_decoder #(
        .IN_DEPTH (IN_DEPTH)
    ) instr_decoder_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_credit (in_credit),
        .ex_ready  (ex_ready),
        .dec       (dec),
        .dec_valid (dec_valid)
    );

    alu_execute alu_execute_i (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .dec_valid  (dec_valid),
        .ex_ready   (ex_ready),
        .res_ready  (res_ready),
        .prev_taken (prev_taken),
        .ex_result  (ex_result),
        .ex_valid   (ex_valid)
    );

    result_stage #(
        .OUT_CREDITS (OUT_CREDITS)
    ) result_stage_i (
        .clk        (clk),
        .rst        (rst),
        .ex_result  (ex_result),
        .ex_valid   (ex_valid),
        .res_ready  (res_ready),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .prev_taken (prev_taken)
    );

endmodule

`default_nettype wire

//--- tb_exc_core.sv
`default_nettype none

module tb_exc_core
    import mips_exc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IN_DEPTH        = 4;
    localparam int OUT_CREDITS     = 4;
    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 40;

    logic         clk        = 1'b0;
    logic         rst        = 1'b1;
    logic         in_valid   = 1'b0;
    instr_in_t    in_instr   = '0;
    logic         in_credit;
    logic         out_valid;
    exec_result_t out_result;
    logic         out_credit = 1'b0;

    instr_in_t    stim [MAX_LINES];
    exec_result_t exp_records [MAX_LINES];
    int           num_lines = 0;
    bit           loaded    = 1'b0;
    int           send_idx;
    int           src_credits;
    int           credit_now;
    int           in_credit_count;
    int           recv_count = 0;
    int           returned;
    int           owed;
    int           pending;
    int           gap;

    exc_core_top #(
        .IN_DEPTH    (IN_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) exc_core_top_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
                                name, got, want));
        end
    endtask

    // write-back and exception fields only count when they apply.
    task automatic compare_record(input int idx, input exec_result_t got);
        exec_result_t want;
        string        tag;
        want = exp_records[idx];
        tag  = $sformatf(" of record %0d", idx);
        check_value({"out_result.pc", tag}, got.pc, want.pc);
        check_value({"out_result.wr_en", tag}, 32'(got.wr_en), 32'(want.wr_en));
        check_value({"out_result.branch_taken", tag}, 32'(got.branch_taken),
                    32'(want.branch_taken));
        check_value({"out_result.exc.exception_happen", tag},
                    32'(got.exc.exception_happen), 32'(want.exc.exception_happen));
        if (want.wr_en) begin
            check_value({"out_result.wr_reg", tag}, 32'(got.wr_reg), 32'(want.wr_reg));
            check_value({"out_result.wr_data", tag}, got.wr_data, want.wr_data);
        end
        if (want.exc.exception_happen) begin
            check_value({"out_result.exc.exc_code", tag}, 32'(got.exc.exc_code),
                        32'(want.exc.exc_code));
            check_value({"out_result.exc.epc", tag}, got.exc.epc, want.exc.epc);
            check_value({"out_result.exc.in_bd", tag}, 32'(got.exc.in_bd),
                        32'(want.exc.in_bd));
            check_value({"out_result.exc.vector", tag}, got.exc.vector, want.exc.vector);
        end
    endtask

    task automatic load_testdata();
        int              fd;
        int              n;
        logic [8*256-1:0] line;
        logic [31:0]     f_pc;
        logic [31:0]     f_instr;
        logic [31:0]     f_wr_en;
        logic [31:0]     f_wr_reg;
        logic [31:0]     f_wr_data;
        logic [31:0]     f_taken;
        logic [31:0]     f_exc;
        logic [31:0]     f_code;
        logic [31:0]     f_epc;
        logic [31:0]     f_bd;
        logic [31:0]     f_vector;
        instr_in_t       word;
        exec_result_t    rec;
        fd = $fopen("exc_core_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open exc_core_testdata.txt");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h\n", f_pc, f_instr, f_wr_en,
                        f_wr_reg, f_wr_data, f_taken, f_exc, f_code, f_epc, f_bd, f_vector);
            if (n == 11) begin
                if (num_lines >= MAX_LINES) begin
                    abort_run("too many lines in exc_core_testdata.txt");
                end
                word.pc                  = f_pc;
                word.instr               = f_instr;
                rec                      = '0;
                rec.pc                   = f_pc;
                rec.wr_en                = f_wr_en[0];
                rec.wr_reg               = f_wr_reg[4:0];
                rec.wr_data              = f_wr_data;
                rec.branch_taken         = f_taken[0];
                rec.exc.exception_happen = f_exc[0];
                rec.exc.exc_code         = exc_code_e'(f_code[4:0]);
                rec.exc.epc              = f_epc;
                rec.exc.in_bd            = f_bd[0];
                rec.exc.vector           = f_vector;
                stim[num_lines]          = word;
                exp_records[num_lines]   = rec;
                num_lines                = num_lines + 1;
            end else if (n <= 0) begin
                // comment line.
                n = $fgets(line, fd);
            end else begin
                abort_run("malformed line in exc_core_testdata.txt");
            end
        end
        $fclose(fd);
        if (num_lines == 0) begin
            abort_run("exc_core_testdata.txt holds no instructions");
        end
    endtask

    // the source sends one word per credit it holds.
    always @(posedge clk) begin
        if (rst) begin
            in_valid        <= 1'b0;
            send_idx        <= 0;
            src_credits     <= IN_DEPTH;
            in_credit_count <= 0;
        end else begin
            credit_now = src_credits + (in_credit ? 1 : 0);
            if (credit_now > IN_DEPTH) begin
                abort_run("in_credit returned more credits than instructions sent");
            end
            if (loaded && (send_idx < num_lines) && (credit_now > 0)) begin
                in_valid    <= 1'b1;
                in_instr    <= stim[send_idx];
                send_idx    <= send_idx + 1;
                src_credits <= credit_now - 1;
            end else begin
                in_valid    <= 1'b0;
                src_credits <= credit_now;
            end
            if (in_credit) begin
                in_credit_count <= in_credit_count + 1;
            end
        end
    end

    // the sink returns each credit after a random gap.
    always @(posedge clk) begin
        if (rst) begin
            out_credit <= 1'b0;
            recv_count <= 0;
            returned   <= 0;
            owed       <= 0;
            gap        <= 0;
        end else begin
            if (out_valid) begin
                if (recv_count >= num_lines) begin
                    abort_run("a record arrived after the last expected one");
                end
                if (recv_count >= returned + OUT_CREDITS) begin
                    abort_run("out_valid pulsed with no output credit left");
                end
                compare_record(recv_count, out_result);
                recv_count <= recv_count + 1;
            end
            if (out_credit) begin
                returned <= returned + 1;
            end
            pending = owed + (out_valid ? 1 : 0);
            if ((pending > 0) && (gap == 0)) begin
                out_credit <= 1'b1;
                owed       <= pending - 1;
                gap        <= $urandom_range(0, 6);
            end else begin
                out_credit <= 1'b0;
                owed       <= pending;
                if (gap > 0) begin
                    gap <= gap - 1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hb98c_23c1));
        load_testdata();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (recv_count < num_lines) begin
            @(posedge clk);
        end
        // give a stray record time to show up.
        repeat (10) @(posedge clk);
        if ((recv_count == num_lines) && (in_credit_count == num_lines)) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            check_value("record count", recv_count, num_lines);
            check_value("in_credit pulse count", in_credit_count, num_lines);
        end
    end

    initial begin
        wait (loaded);
        repeat (num_lines * CYCLES_PER_LINE) @(posedge clk);
        abort_run($sformatf("timeout, records stopped arriving after %0d of %0d",
                            recv_count, num_lines));
    end

endmodule

`default_nettype wire

//--- exc_core_testdata.txt
# columns in hex: pc instr wr_en wr_reg wr_data taken exc code epc in_bd vector
# wr_reg and wr_data apply with wr_en set, code to vector apply with exc set
00400000 24011234 1 01 00001234 0 0 00 00000000 0 00000000
00400004 2402fff0 1 02 fffffff0 0 0 00 00000000 0 00000000
00400008 00221821 1 03 00001224 0 0 00 00000000 0 00000000
0040000c 00222023 1 04 00001244 0 0 00 00000000 0 00000000
00400010 00622824 1 05 00001220 0 0 00 00000000 0 00000000
00400014 00243025 1 06 00001274 0 0 00 00000000 0 00000000
00400018 00243826 1 07 00000070 0 0 00 00000000 0 00000000
0040001c 0041402a 1 08 00000001 0 0 00 00000000 0 00000000
00400020 0022482a 1 09 00000000 0 0 00 00000000 0 00000000
00400024 400a7800 1 0a 80000000 0 0 00 00000000 0 00000000
00400028 240bffff 1 0b ffffffff 0 0 00 00000000 0 00000000
0040002c 014b6021 1 0c 7fffffff 0 0 00 00000000 0 00000000
00400030 018c6820 0 00 00000000 0 1 0c 00400030 0 bfc00380
00400034 018c6821 1 0d fffffffe 0 0 00 00000000 0 00000000
00400038 218e0001 0 00 00000000 0 1 0c 00400038 0 bfc00380
0040003c 01417822 0 00 00000000 0 1 0c 0040003c 0 bfc00380
00400040 00220034 0 00 00000000 0 0 00 00000000 0 00000000
00400044 00210034 0 00 00000000 0 1 0d 00400044 0 bfc00380
00400048 00210036 0 00 00000000 0 0 00 00000000 0 00000000
0040004c 00220036 0 00 00000000 0 1 0d 0040004c 0 bfc00380
00400050 0000000c 0 00 00000000 0 1 08 00400050 0 bfc00380
00400054 0000000d 0 00 00000000 0 1 09 00400054 0 bfc00380
00400058 fc000000 0 00 00000000 0 1 0a 00400058 0 bfc00380
0040005c 10210004 0 00 00000000 1 0 00 00000000 0 00000000
00400060 0000000c 0 00 00000000 0 1 08 0040005c 1 bfc00380
00400064 14210004 0 00 00000000 0 0 00 00000000 0 00000000
00400068 0000000d 0 00 00000000 0 1 09 00400068 0 bfc00380
0040006c 14220004 0 00 00000000 1 0 00 00000000 0 00000000
00400070 00210034 0 00 00000000 0 1 0d 0040006c 1 bfc00380
00400074 40107000 1 10 0040006c 0 0 00 00000000 0 00000000
00400078 40116800 1 11 80000034 0 0 00 00000000 0 00000000
0040007c 25522000 1 12 80002000 0 0 00 00000000 0 00000000
00400080 40927800 0 00 00000000 0 0 00 00000000 0 00000000
00400084 40806000 0 00 00000000 0 0 00 00000000 0 00000000
00400088 0000000c 0 00 00000000 0 1 08 00400088 0 80002180
0040008c 40136000 1 13 00000000 0 0 00 00000000 0 00000000

//--- filelist.f
mips_exc_pkg.sv
instr_decoder.sv
exception_controller.sv
cop0_regs.sv
alu_execute.sv
result_stage.sv
exc_core_top.sv
tb_exc_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module tb_exc_core -f filelist.f -o Vtb_exc_core || exit 1
out=$(./obj_dir/Vtb_exc_core 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
